//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_core_glue
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/bridge_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// host bridge side of the glue
// read data mux by address region, data table lookup of the file size,
// read request stretching toward the host and the completion pulse
////////////////////////////////////////////////////////////////////////////

`include "core_glue_consts.svh"

module bridge_ctrl (
  input  logic                         clk_sys,
  input  logic                         rst_n,
  input  core_glue_pkg::bridge_addr_t  bridge_addr,
  input  core_glue_pkg::bridge_data_t  cmd_rd_data,
  input  core_glue_pkg::glue_status_t  status,
  input  core_glue_pkg::bridge_data_t  datatable_q,
  input  core_glue_pkg::dataslot_req_t core_req,
  input  logic                         target_done,
  output core_glue_pkg::bridge_data_t  bridge_rd_data,
  output core_glue_pkg::table_addr_t   table_addr,
  output core_glue_pkg::bridge_data_t  file_size,
  output core_glue_pkg::dataslot_req_t target_req,
  output logic                         complete_pulse
);

  localparam int STRETCH   = `CORE_GLUE_READ_STRETCH;
  localparam int STRETCH_W = $clog2(STRETCH + 1);

  // status bits padded out to a full bus word
  core_glue_pkg::bridge_data_t status_word;

  // read stretch state
  logic                 read_prev;
  logic                 read_rise;
  logic [STRETCH_W-1:0] stretch_cnt;

  // request payload, one cycle behind the core
  logic [31:0]             offset_q;
  logic [31:0]             length_q;
  core_glue_pkg::slot_id_t slot_id_q;

  logic done_prev;

  ////////////////////////////////////////////////////////////////////////////
  // bridge read mux
  ////////////////////////////////////////////////////////////////////////////

  assign status_word = core_glue_pkg::bridge_data_t'(status);

  // decode on the top byte only
  always_ff @(posedge clk_sys) begin
    case (bridge_addr[31:24])
      `CORE_GLUE_REGION_CMD:    bridge_rd_data <= cmd_rd_data;
      `CORE_GLUE_REGION_STATUS: bridge_rd_data <= status_word;
      default:                  bridge_rd_data <= '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // data table, file size of the requested slot
  ////////////////////////////////////////////////////////////////////////////

  // size word sits at 2*id + 1
  always_ff @(posedge clk_sys) begin
    table_addr <= {core_req.slot_id[8:0], 1'b1};
    file_size  <= datatable_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // read request stretch
  ////////////////////////////////////////////////////////////////////////////

  assign read_rise = core_req.read & ~read_prev;

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      read_prev   <= 1'b0;
      stretch_cnt <= '0;
    end else begin
      read_prev <= core_req.read;
      // a rise during a stretch is absorbed, length stays fixed
      if (read_rise && stretch_cnt == '0) begin
        stretch_cnt <= STRETCH_W'(STRETCH);
      end else if (stretch_cnt != '0) begin
        stretch_cnt <= stretch_cnt - 1'b1;
      end
    end
  end

  // payload follows the core every cycle
  always_ff @(posedge clk_sys) begin
    offset_q  <= core_req.offset;
    length_q  <= core_req.length;
    slot_id_q <= core_req.slot_id;
  end

  assign target_req.read    = (stretch_cnt != '0);
  assign target_req.offset  = offset_q;
  assign target_req.length  = length_q;
  assign target_req.slot_id = slot_id_q;

  ////////////////////////////////////////////////////////////////////////////
  // completion, one pulse per done rise
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      done_prev      <= 1'b0;
      complete_pulse <= 1'b0;
    end else begin
      done_prev      <= target_done;
      complete_pulse <= target_done & ~done_prev;
    end
  end

endmodule

//--- rtl/core_glue_consts.svh
////////////////////////////////////////////////////////////////////////////
// shared constants for the core glue logic
// address regions, controller key bits, synchronizer depth and the
// hold and stretch lengths; include ahead of any module that needs them
////////////////////////////////////////////////////////////////////////////

`ifndef CORE_GLUE_CONSTS_SVH
`define CORE_GLUE_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// bridge address regions, matched on the top address byte
////////////////////////////////////////////////////////////////////////////

// command block of the host command handler
`define CORE_GLUE_REGION_CMD 8'hF8
// glue status word
`define CORE_GLUE_REGION_STATUS 8'h10

////////////////////////////////////////////////////////////////////////////
// controller and reset timing
////////////////////////////////////////////////////////////////////////////

// face_start in the controller key bitmap
`define CORE_GLUE_KEY_START 15
// button synchronizer depth
`define CORE_GLUE_SYNC_STAGES 3
// hold cycles after a start press
`define CORE_GLUE_RESET_HOLD 16'hFFFF

////////////////////////////////////////////////////////////////////////////
// data slot read request
////////////////////////////////////////////////////////////////////////////

// stretched read request length, in cycles
`define CORE_GLUE_READ_STRETCH 7

`endif

//--- rtl/core_glue_pkg.sv
////////////////////////////////////////////////////////////////////////////
// types shared by the glue modules
// vector typedefs for meaningful widths and the packed structs that
// carry pixels, syncs, data slot requests and the status bits
////////////////////////////////////////////////////////////////////////////

package core_glue_pkg;

  // host bridge, byte address and read data
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // data slot id and data table word address
  typedef logic [15:0] slot_id_t;
  typedef logic [9:0]  table_addr_t;

  // reset hold timer
  typedef logic [15:0] hold_cnt_t;

  // controller key bitmap, start is bit 15
  typedef logic [31:0] cont_key_t;

  // core pixel, 16 bit colour
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  // scaler pixel, 24 bit colour
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  typedef struct packed {
    logic de;
    logic hs;
    logic vs;
  } video_sync_t;

  // data slot read request, core side and host side share the layout
  typedef struct packed {
    logic         read;
    logic [31:0]  offset;
    logic [31:0]  length;
    slot_id_t     slot_id;
  } dataslot_req_t;

  // status bits, zero-extended onto the bridge
  typedef struct packed {
    logic core_reset;
    logic download;
    logic hold_active;
  } glue_status_t;

endpackage

//--- rtl/core_glue_top.sv
////////////////////////////////////////////////////////////////////////////
// top level of the core glue logic
// connects reset control, the bridge side and the video output stage;
// all on clk_sys with the asynchronous rst_n
////////////////////////////////////////////////////////////////////////////

module core_glue_top (
  input  logic                         clk_sys,
  input  logic                         rst_n,

  // host reset, controller and data slot commands
  input  logic                         host_reset_n,
  input  core_glue_pkg::cont_key_t     cont1_key,
  input  logic                         dataslot_requestwrite,
  input  logic                         dataslot_allcomplete,
  output logic                         core_reset,

  // host bridge and data table
  input  core_glue_pkg::bridge_addr_t  bridge_addr,
  input  core_glue_pkg::bridge_data_t  cmd_rd_data,
  input  core_glue_pkg::bridge_data_t  datatable_q,
  output core_glue_pkg::bridge_data_t  bridge_rd_data,
  output core_glue_pkg::table_addr_t   table_addr,
  output core_glue_pkg::bridge_data_t  file_size,

  // data slot read requests
  input  core_glue_pkg::dataslot_req_t core_req,
  input  logic                         target_done,
  output core_glue_pkg::dataslot_req_t target_req,
  output logic                         complete_pulse,

  // video from the core and out to the scaler
  input  core_glue_pkg::rgb565_t       pix,
  input  core_glue_pkg::video_sync_t   sync,
  output core_glue_pkg::rgb888_t       video_rgb,
  output logic                         video_de,
  output logic                         video_hs,
  output logic                         video_vs
);

  // reset state for the bridge status word
  core_glue_pkg::glue_status_t status;

  reset_ctrl u_reset_ctrl (
    .clk_sys               (clk_sys),
    .rst_n                 (rst_n),
    .host_reset_n          (host_reset_n),
    .cont1_key             (cont1_key),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .status                (status),
    .core_reset            (core_reset)
  );

  bridge_ctrl u_bridge_ctrl (
    .clk_sys        (clk_sys),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .cmd_rd_data    (cmd_rd_data),
    .status         (status),
    .datatable_q    (datatable_q),
    .core_req       (core_req),
    .target_done    (target_done),
    .bridge_rd_data (bridge_rd_data),
    .table_addr     (table_addr),
    .file_size      (file_size),
    .target_req     (target_req),
    .complete_pulse (complete_pulse)
  );

  video_out u_video_out (
    .clk_sys   (clk_sys),
    .rst_n     (rst_n),
    .pix       (pix),
    .sync      (sync),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
  );

endmodule

//--- rtl/reset_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// core reset generation
// merges host reset, the download window and a hold timer started by
// the controller start button into one registered core reset
////////////////////////////////////////////////////////////////////////////

`include "core_glue_consts.svh"

module reset_ctrl (
  input  logic                       clk_sys,
  input  logic                       rst_n,
  input  logic                       host_reset_n,
  input  core_glue_pkg::cont_key_t   cont1_key,
  input  logic                       dataslot_requestwrite,
  input  logic                       dataslot_allcomplete,
  output core_glue_pkg::glue_status_t status,
  output logic                       core_reset
);

  localparam int SYNC_STAGES = `CORE_GLUE_SYNC_STAGES;

  // start button synchronizer, bit 0 is the first stage
  logic [SYNC_STAGES-1:0] start_sync;
  // edge register behind the last stage
  logic start_prev;
  logic start_rise;

  core_glue_pkg::hold_cnt_t hold_cnt;
  logic hold_active;
  logic download;

  ////////////////////////////////////////////////////////////////////////////
  // button sync and edge detect
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      start_sync <= '0;
      start_prev <= 1'b0;
    end else begin
      start_sync <= {start_sync[SYNC_STAGES-2:0], cont1_key[`CORE_GLUE_KEY_START]};
      start_prev <= start_sync[SYNC_STAGES-1];
    end
  end

  assign start_rise = start_sync[SYNC_STAGES-1] & ~start_prev;

  ////////////////////////////////////////////////////////////////////////////
  // hold timer and download window
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt <= '0;
    end else if (start_rise) begin
      // a new press restarts the full hold
      hold_cnt <= `CORE_GLUE_RESET_HOLD;
    end else if (hold_active) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign hold_active = (hold_cnt != '0);

  // open on requestwrite, close on allcomplete
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      download <= 1'b0;
    end else if (dataslot_requestwrite) begin
      download <= 1'b1;
    end else if (dataslot_allcomplete) begin
      download <= 1'b0;
    end
  end

  // core held in reset straight out of rst_n
  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      core_reset <= 1'b1;
    end else begin
      core_reset <= ~host_reset_n | download | hold_active;
    end
  end

  // status word for the bridge
  assign status.core_reset  = core_reset;
  assign status.download    = download;
  assign status.hold_active = hold_active;

endmodule

//--- rtl/video_out.sv
////////////////////////////////////////////////////////////////////////////
// video output stage toward the scaler
// rgb565 to rgb888 expansion, one cycle sync delay, blanking outside
// the delayed data enable and a data enable widened by two cycles
////////////////////////////////////////////////////////////////////////////

module video_out (
  input  logic                       clk_sys,
  input  logic                       rst_n,
  input  core_glue_pkg::rgb565_t     pix,
  input  core_glue_pkg::video_sync_t sync,
  output core_glue_pkg::rgb888_t     video_rgb,
  output logic                       video_de,
  output logic                       video_hs,
  output logic                       video_vs
);

  // expanded pixel, before the delay
  core_glue_pkg::rgb888_t pix888;

  // syncs one cycle back, de of two cycles back
  core_glue_pkg::video_sync_t sync_q;
  logic de_qq;

  ////////////////////////////////////////////////////////////////////////////
  // colour expansion
  ////////////////////////////////////////////////////////////////////////////

  // top bits repeated into the new low bits, full scale stays full
  assign pix888.r = {pix.r, pix.r[4:2]};
  assign pix888.g = {pix.g, pix.g[5:4]};
  assign pix888.b = {pix.b, pix.b[4:2]};

  ////////////////////////////////////////////////////////////////////////////
  // delay and blanking
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      sync_q    <= '0;
      de_qq     <= 1'b0;
      video_rgb <= '0;
    end else begin
      sync_q <= sync;
      de_qq  <= sync_q.de;
      // black outside the active area
      video_rgb <= sync.de ? pix888 : '0;
    end
  end

  assign video_hs = sync_q.hs;
  assign video_vs = sync_q.vs;

  // opens with de, trails its fall by two cycles
  assign video_de = sync.de | sync_q.de | de_qq;

endmodule

//--- sim/core_glue_assert.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks bound into bridge_ctrl and video_out
// pulse width, read stretch length and blanking of the video output
////////////////////////////////////////////////////////////////////////////

`include "core_glue_consts.svh"

module core_glue_assert (
  input logic clk_sys,
  input logic rst_n,
  input logic one_shot,
  input logic stretch,
  input logic blank_ok
);
  timeunit 1ns;
  timeprecision 1ns;

  // cycles of stretch high before the current one
  logic [3:0] run;

  always_ff @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      run <= '0;
    end else begin
      run <= stretch ? run + 4'd1 : 4'd0;
    end
  end

  pulse_one_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
    one_shot |=> !one_shot)
    else $error("complete pulse lasted two cycles");

  stretch_max: assert property (@(posedge clk_sys) disable iff (!rst_n)
    stretch |-> run < 4'(`CORE_GLUE_READ_STRETCH))
    else $error("read request longer than the stretch length");

  blank_zero: assert property (@(posedge clk_sys) disable iff (!rst_n) blank_ok)
    else $error("video pixel not black outside data enable");

endmodule

bind bridge_ctrl core_glue_assert u_bridge_assert (
  .clk_sys  (clk_sys),
  .rst_n    (rst_n),
  .one_shot (complete_pulse),
  .stretch  (target_req.read),
  .blank_ok (1'b1)
);

bind video_out core_glue_assert u_video_assert (
  .clk_sys  (clk_sys),
  .rst_n    (rst_n),
  .one_shot (1'b0),
  .stretch  (1'b0),
  .blank_ok (sync_q.de || video_rgb == '0)
);

//--- sim/tb_checker.sv
////////////////////////////////////////////////////////////////////////////
// result checker for the core glue testbench
// watches the DUT outputs, compares them on request, keeps error counts
// and prints one line per finished test plus a closing count line
////////////////////////////////////////////////////////////////////////////

module tb_checker (
  input core_glue_pkg::bridge_data_t  bridge_rd_data,
  input core_glue_pkg::table_addr_t   table_addr,
  input core_glue_pkg::bridge_data_t  file_size,
  input core_glue_pkg::dataslot_req_t target_req,
  input logic                         complete_pulse,
  input logic                         core_reset,
  input core_glue_pkg::rgb888_t       video_rgb,
  input logic                         video_hs,
  input logic                         video_vs
);
  timeunit 1ns;
  timeprecision 1ns;

  int err_cnt = 0;
  int check_cnt = 0;
  int test_cnt = 0;
  int test_errs = 0;

  // compare one DUT output picked by its name
  task automatic compare(input string sig, input logic [31:0] exp);
    logic [31:0] got;
    case (sig)
      "bridge_rd_data":     got = bridge_rd_data;
      "table_addr":         got = {22'h0, table_addr};
      "file_size":          got = file_size;
      "target_req.offset":  got = target_req.offset;
      "target_req.length":  got = target_req.length;
      "target_req.slot_id": got = {16'h0, target_req.slot_id};
      "complete_pulse":     got = {31'h0, complete_pulse};
      "core_reset":         got = {31'h0, core_reset};
      "video_rgb":          got = {8'h0, video_rgb};
      "video_hs":           got = {31'h0, video_hs};
      "video_vs":           got = {31'h0, video_vs};
      default:              got = 32'hDEAD_BEEF;
    endcase
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      test_errs++;
      $display("ERROR %s: got 0x%08h, expected 0x%08h", sig, got, exp);
    end
  endtask

  // counted cycles or pulses against an allowed range
  task automatic compare_range(input string what, input int got, input int lo, input int hi);
    check_cnt++;
    if (got < lo || got > hi) begin
      err_cnt++;
      test_errs++;
      $display("%s was %0d, but should be between %0d and %0d", what, got, lo, hi);
    end
  endtask

  task automatic begin_test();
    test_errs = 0;
  endtask

  task automatic end_test(input int id, input string name);
    test_cnt++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok", id, name);
    end else begin
      $display("test %0d %s: %0d errors", id, name, test_errs);
    end
  endtask

  task automatic report();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
  endtask

endmodule

//--- sim/tb_clk_gen.sv
////////////////////////////////////////////////////////////////////////////
// clock and reset for the testbench
// clk_sys at a 100 ns period, rst_n held low for the first 10 cycles
////////////////////////////////////////////////////////////////////////////

module tb_clk_gen (
  output logic clk_sys,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    clk_sys = 1'b0;
    rst_n   = 1'b0;
    repeat (10) @(posedge clk_sys);
    rst_n <= 1'b1;
  end

  always #50 clk_sys = ~clk_sys;

endmodule

//--- sim/tb_core_glue.sv
////////////////////////////////////////////////////////////////////////////
// testbench top for the core glue logic
// applies a table of tests to core_glue_top in a loop; tb_checker does
// the comparing and a cycle counter bounds the run
////////////////////////////////////////////////////////////////////////////

`include "core_glue_consts.svh"

module tb_core_glue;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int N_TESTS = 14;
  localparam int MARGIN  = 500;

  // test kinds
  localparam logic [3:0] K_RD = 0, K_SLOT = 1, K_STRETCH = 2, K_DONE = 3;
  localparam logic [3:0] K_PIX = 4, K_WIDE = 5, K_DL = 6, K_HOST = 7, K_START = 8;

  // one table row
  // rnd marks a row whose a and b are drawn at start
  typedef struct packed {
    logic [7:0]  id;
    logic [3:0]  kind;
    logic        rnd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
  } test_rec_t;

  logic clk_sys;
  logic rst_n;
  logic host_reset_n;
  core_glue_pkg::cont_key_t     cont1_key;
  logic dataslot_requestwrite;
  logic dataslot_allcomplete;
  logic core_reset;
  core_glue_pkg::bridge_addr_t  bridge_addr;
  core_glue_pkg::bridge_data_t  cmd_rd_data;
  core_glue_pkg::bridge_data_t  datatable_q;
  core_glue_pkg::bridge_data_t  bridge_rd_data;
  core_glue_pkg::table_addr_t   table_addr;
  core_glue_pkg::bridge_data_t  file_size;
  core_glue_pkg::dataslot_req_t core_req;
  logic target_done;
  core_glue_pkg::dataslot_req_t target_req;
  logic complete_pulse;
  core_glue_pkg::rgb565_t       pix;
  core_glue_pkg::video_sync_t   sync;
  core_glue_pkg::rgb888_t       video_rgb;
  logic video_de;
  logic video_hs;
  logic video_vs;

  test_rec_t tests [N_TESTS];
  int cycle_cnt = 0;
  int cycle_limit = 0;

  tb_clk_gen u_clk_gen (.clk_sys(clk_sys), .rst_n(rst_n));

  core_glue_top u_dut (.*);

  tb_checker u_chk (
    .bridge_rd_data (bridge_rd_data),
    .table_addr     (table_addr),
    .file_size      (file_size),
    .target_req     (target_req),
    .complete_pulse (complete_pulse),
    .core_reset     (core_reset),
    .video_rgb      (video_rgb),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

  ////////////////////////////////////////////////////////////////////////////
  // expected values from the glue rules
  ////////////////////////////////////////////////////////////////////////////

  // top bits of each channel repeated into the new low bits
  function automatic logic [23:0] expand565(input logic [15:0] p);
    return {p[15:11], p[15:13], p[10:5], p[10:9], p[4:0], p[4:2]};
  endfunction

  function automatic logic [31:0] exp_of(input test_rec_t t);
    logic [9:0] ta;
    // twice the low 10 bits of the id plus one
    ta = t.a[9:0] * 10'd2 + 10'd1;
    case (t.kind)
      // status word is zero while idle
      K_RD:    return (t.a[31:24] == `CORE_GLUE_REGION_CMD) ? t.b : 32'h0;
      K_SLOT:  return {22'h0, ta};
      K_PIX:   return t.b[0] ? {8'h0, expand565(t.a[15:0])} : 32'h0;
      default: return 32'h0;
    endcase
  endfunction

  function automatic int budget_of(input logic [3:0] kind);
    return (kind == K_START) ? 40 : 30;
  endfunction

  function automatic string name_of(input logic [3:0] kind);
    case (kind)
      K_RD:      return "bridge read";
      K_SLOT:    return "data table";
      K_STRETCH: return "read stretch";
      K_DONE:    return "done pulse";
      K_PIX:     return "pixel";
      K_WIDE:    return "de widening";
      K_DL:      return "download window";
      K_HOST:    return "host reset";
      default:   return "start hold";
    endcase
  endfunction

  task automatic load_table();
    tests[0]  = '{8'd1,  K_RD,      1'b0, 32'hF800_0010, 32'hCAFE_0001, 32'h0};
    tests[1]  = '{8'd2,  K_RD,      1'b0, 32'h1000_0000, 32'h5555_AAAA, 32'h0};
    tests[2]  = '{8'd3,  K_RD,      1'b0, 32'h2000_0004, 32'h0000_1234, 32'h0};
    tests[3]  = '{8'd4,  K_RD,      1'b1, 32'h0,         32'h0,         32'h0};
    tests[4]  = '{8'd5,  K_SLOT,    1'b1, 32'h0,         32'h0,         32'h0};
    tests[5]  = '{8'd6,  K_SLOT,    1'b1, 32'h0,         32'h0,         32'h0};
    tests[6]  = '{8'd7,  K_STRETCH, 1'b0, 32'h0000_0100, 32'h0000_0040, 32'h0};
    tests[7]  = '{8'd8,  K_DONE,    1'b0, 32'h0,         32'h0,         32'h0};
    tests[8]  = '{8'd9,  K_PIX,     1'b1, 32'h0,         32'h7,         32'h0};
    tests[9]  = '{8'd10, K_PIX,     1'b1, 32'h0,         32'h2,         32'h0};
    tests[10] = '{8'd11, K_WIDE,    1'b0, 32'h5,         32'h0,         32'h0};
    tests[11] = '{8'd12, K_DL,      1'b0, 32'h0,         32'h0,         32'h0};
    tests[12] = '{8'd13, K_HOST,    1'b0, 32'h0,         32'h0,         32'h0};
    tests[13] = '{8'd14, K_START,   1'b0, 32'h0,         32'h0,         32'h0};
    for (int i = 0; i < N_TESTS; i++) begin
      if (tests[i].rnd) begin
        tests[i].a = $urandom;
        // pixel rows keep their sync bits in b
        if (tests[i].kind != K_PIX) tests[i].b = $urandom;
      end
      tests[i].exp = exp_of(tests[i]);
      cycle_limit += budget_of(tests[i].kind);
    end
    cycle_limit += int'(`CORE_GLUE_RESET_HOLD) + MARGIN + 10;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one task per test kind
  ////////////////////////////////////////////////////////////////////////////

  task automatic read_bridge(input test_rec_t t);
    @(posedge clk_sys);
    bridge_addr <= t.a;
    cmd_rd_data <= t.b;
    @(posedge clk_sys);
    @(negedge clk_sys);
    u_chk.compare("bridge_rd_data", t.exp);
  endtask

  task automatic lookup_slot(input test_rec_t t);
    @(posedge clk_sys);
    core_req.slot_id <= t.a[15:0];
    @(posedge clk_sys);
    datatable_q <= t.b;
    @(negedge clk_sys);
    u_chk.compare("table_addr", t.exp);
    @(posedge clk_sys);
    @(negedge clk_sys);
    u_chk.compare("file_size", t.b);
  endtask

  task automatic stretch_read(input test_rec_t t);
    int hi;
    int first;
    hi = 0;
    first = -1;
    @(posedge clk_sys);
    core_req <= '{read: 1'b1, offset: t.a, length: t.b, slot_id: 16'h0042};
    for (int i = 0; i < 14; i++) begin
      @(posedge clk_sys);
      if (i == 2) core_req.read <= 1'b0;
      @(negedge clk_sys);
      if (target_req.read) begin
        hi++;
        if (first < 0) first = i;
      end
      if (i == 0) begin
        u_chk.compare("target_req.offset", t.a);
        u_chk.compare("target_req.length", t.b);
        u_chk.compare("target_req.slot_id", 32'h42);
      end
    end
    u_chk.compare_range("cycles of stretched read", hi, 7, 7);
    u_chk.compare_range("cycles from request edge to read", first + 1, 1, 1);
  endtask

  task automatic pulse_done();
    @(posedge clk_sys);
    target_done <= 1'b1;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_sys);
      if (i == 8) target_done <= 1'b0;
      @(negedge clk_sys);
      // one pulse the cycle after the rise, none while the level holds
      u_chk.compare("complete_pulse", (i == 0) ? 32'h1 : 32'h0);
    end
  endtask

  task automatic send_pixel(input test_rec_t t);
    @(posedge clk_sys);
    pix  <= core_glue_pkg::rgb565_t'(t.a[15:0]);
    sync <= core_glue_pkg::video_sync_t'({t.b[0], t.b[1], t.b[2]});
    @(posedge clk_sys);
    sync <= '0;
    @(negedge clk_sys);
    u_chk.compare("video_rgb", t.exp);
    u_chk.compare("video_hs", {31'h0, t.b[1]});
    u_chk.compare("video_vs", {31'h0, t.b[2]});
  endtask

  task automatic widen_de(input test_rec_t t);
    int n;
    int cnt;
    n = int'(t.a[3:0]);
    cnt = 0;
    @(posedge clk_sys);
    sync.de <= 1'b1;
    for (int i = 0; i < n + 8; i++) begin
      @(negedge clk_sys);
      if (video_de) cnt++;
      @(posedge clk_sys);
      if (i == n - 1) sync.de <= 1'b0;
    end
    u_chk.compare_range("cycles of widened de", cnt, n + 2, n + 2);
  endtask

  task automatic open_download();
    @(posedge clk_sys);
    dataslot_requestwrite <= 1'b1;
    @(posedge clk_sys);
    dataslot_requestwrite <= 1'b0;
    repeat (3) @(posedge clk_sys);
    @(negedge clk_sys);
    u_chk.compare("core_reset", 32'h1);
    // status word with core_reset and download set
    @(posedge clk_sys);
    bridge_addr <= 32'h1000_0000;
    @(posedge clk_sys);
    @(negedge clk_sys);
    u_chk.compare("bridge_rd_data", 32'h6);
    @(posedge clk_sys);
    dataslot_allcomplete <= 1'b1;
    bridge_addr <= '0;
    @(posedge clk_sys);
    dataslot_allcomplete <= 1'b0;
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    u_chk.compare("core_reset", 32'h0);
  endtask

  task automatic force_host_reset();
    @(posedge clk_sys);
    host_reset_n <= 1'b0;
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    u_chk.compare("core_reset", 32'h1);
    @(posedge clk_sys);
    host_reset_n <= 1'b1;
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    u_chk.compare("core_reset", 32'h0);
  endtask

  task automatic press_start();
    int k;
    int m;
    k = 0;
    m = 0;
    @(posedge clk_sys);
    cont1_key[`CORE_GLUE_KEY_START] <= 1'b1;
    while (!core_reset && k < 20) begin
      @(posedge clk_sys);
      k++;
      @(negedge clk_sys);
    end
    u_chk.compare_range("cycles from start press to core reset", k, 1, 5);
    while (core_reset && m < int'(`CORE_GLUE_RESET_HOLD) + 100) begin
      @(posedge clk_sys);
      if (m == 0) cont1_key[`CORE_GLUE_KEY_START] <= 1'b0;
      m++;
      @(negedge clk_sys);
    end
    u_chk.compare_range("cycles of reset hold", m,
      int'(`CORE_GLUE_RESET_HOLD) - 2, int'(`CORE_GLUE_RESET_HOLD) + 2);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_sys) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("run stopped by timeout after %0d cycles", cycle_cnt);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h3d9d_d9b0));
    host_reset_n          <= 1'b1;
    cont1_key             <= '0;
    dataslot_requestwrite <= 1'b0;
    dataslot_allcomplete  <= 1'b0;
    bridge_addr           <= '0;
    cmd_rd_data           <= '0;
    datatable_q           <= '0;
    core_req              <= '0;
    target_done           <= 1'b0;
    pix                   <= '0;
    sync                  <= '0;
    load_table();
    @(posedge rst_n);
    repeat (2) @(posedge clk_sys);
    for (int i = 0; i < N_TESTS; i++) begin
      u_chk.begin_test();
      case (tests[i].kind)
        K_RD:      read_bridge(tests[i]);
        K_SLOT:    lookup_slot(tests[i]);
        K_STRETCH: stretch_read(tests[i]);
        K_DONE:    pulse_done();
        K_PIX:     send_pixel(tests[i]);
        K_WIDE:    widen_de(tests[i]);
        K_DL:      open_download();
        K_HOST:    force_host_reset();
        default:   press_start();
      endcase
      u_chk.end_test(int'(tests[i].id), name_of(tests[i].kind));
    end
    u_chk.report();
    if (u_chk.err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+rtl
rtl/core_glue_pkg.sv
rtl/reset_ctrl.sv
rtl/bridge_ctrl.sv
rtl/video_out.sv
rtl/core_glue_top.sv
sim/tb_clk_gen.sv
sim/tb_checker.sv
sim/core_glue_assert.sv
sim/tb_core_glue.sv
